//--- files.f
+incdir+hw
hw/lsu_pkg.sv
hw/local_mem_port.sv
hw/global_mem_port.sv
hw/wb_combiner.sv
hw/lsu_top.sv
tb/lsu_mem_models.sv
tb/lsu_props.sv
tb/lsu_tb.sv

//--- tb/lsu_tb.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_tb;

    import lsu_pkg::*;

    localparam int NUM_ROWS       = 19;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * 8 + 50;
    localparam logic [`LSU_VEC_W-1:0] VEC_PAT = 128'h0123_4567_89ab_cdef_fedc_ba98_7654_3210;

    typedef struct packed {
        logic                   is_store;
        logic                   is_vector;
        size_e                  size;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_VEC_W-1:0]  wdata;
        logic [`LSU_REG_W-1:0]  rd;
        logic [`LSU_VEC_W-1:0]  exp;
    } row_t;

    logic                   clk;
    logic                   rst_n;
    logic                   valid_in;
    lsu_req_t               req;
    logic                   stall;
    logic                   busy;
    logic                   local_req_valid;
    local_req_t             local_req;
    logic [`LSU_VEC_W-1:0]  local_rdata;
    logic                   global_req_valid;
    global_req_t            global_req;
    logic                   global_resp_valid;
    global_resp_t           global_resp;
    logic                   wb_valid;
    wb_t                    wb;

    row_t                   rows [NUM_ROWS];
    int                     cycle_count = 0;

    lsu_top dut0 (
        .clk               (clk),
        .rst_n             (rst_n),
        .valid_in          (valid_in),
        .req               (req),
        .stall             (stall),
        .busy              (busy),
        .local_req_valid   (local_req_valid),
        .local_req         (local_req),
        .local_rdata       (local_rdata),
        .global_req_valid  (global_req_valid),
        .global_req        (global_req),
        .global_resp_valid (global_resp_valid),
        .global_resp       (global_resp),
        .wb_valid          (wb_valid),
        .wb                (wb)
    );

    bram_model u_bram (
        .clk       (clk),
        .rst_n     (rst_n),
        .req_valid (local_req_valid),
        .req       (local_req),
        .rdata     (local_rdata)
    );

    global_mem_model u_gmem (
        .clk        (clk),
        .rst_n      (rst_n),
        .req_valid  (global_req_valid),
        .req        (global_req),
        .resp_valid (global_resp_valid),
        .resp       (global_resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // ------------------------------------------------------------------------
    // Failure reporting
    // ------------------------------------------------------------------------
    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic report_mismatch(input string name, input logic [`LSU_VEC_W-1:0] got,
                                   input logic [`LSU_VEC_W-1:0] exp);
        stop_with_failure($sformatf("ERR %s got %h expected %h", name, got, exp));
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            stop_with_failure("Simulation ran past its cycle limit");
        end
    end

    task automatic check_idle(input string when);
        assert (!busy && !stall && !local_req_valid && !global_req_valid && !wb_valid)
            else stop_with_failure($sformatf("LSU not idle %s", when));
    endtask

    // ------------------------------------------------------------------------
    // Stimulus table
    // ------------------------------------------------------------------------
    function automatic row_t make_row(input logic st, input logic vec, input size_e size,
                                      input logic [`LSU_ADDR_W-1:0] addr,
                                      input logic [`LSU_VEC_W-1:0] wdata,
                                      input logic [`LSU_REG_W-1:0] rd,
                                      input logic [`LSU_VEC_W-1:0] exp);
        row_t r;
        r = '{is_store: st, is_vector: vec, size: size, addr: addr, wdata: wdata,
              rd: rd, exp: exp};
        return r;
    endfunction

    task automatic fill_table();
        // Local BRAM banks 1 and 3 of line 2 and then a vector line
        rows[0]  = make_row(1, 0, SZ_WORD,   32'h0000_0021, 128'hcafe_0001, 5'd0, '0);
        rows[1]  = make_row(0, 0, SZ_WORD,   32'h0000_0021, '0, 5'd3, 128'hcafe_0001);
        rows[2]  = make_row(1, 0, SZ_WORD,   32'h0000_0023, 128'h1234_5678, 5'd0, '0);
        rows[3]  = make_row(0, 0, SZ_WORD,   32'h0000_0023, '0, 5'd4, 128'h1234_5678);
        rows[4]  = make_row(0, 0, SZ_WORD,   32'h0000_0021, '0, 5'd9, 128'hcafe_0001);
        rows[5]  = make_row(1, 1, SZ_WORD,   32'h0000_0040, VEC_PAT, 5'd0, '0);
        rows[6]  = make_row(0, 1, SZ_WORD,   32'h0000_0048, '0, 5'd5, VEC_PAT);
        // Global word and then byte and half merged into it
        rows[7]  = make_row(1, 0, SZ_WORD,   32'h8000_0010, 128'ha1b2_c3d4, 5'd0, '0);
        rows[8]  = make_row(0, 0, SZ_WORD,   32'h8000_0010, '0, 5'd6, 128'ha1b2_c3d4);
        rows[9]  = make_row(1, 0, SZ_BYTE,   32'h8000_0011, 128'h55, 5'd0, '0);
        rows[10] = make_row(1, 0, SZ_HALF,   32'h8000_0012, 128'h9977, 5'd0, '0);
        rows[11] = make_row(0, 0, SZ_WORD,   32'h8000_0010, '0, 5'd7, 128'h9977_55d4);
        // Signed and unsigned subword loads
        rows[12] = make_row(0, 0, SZ_BYTE,   32'h8000_0013, '0, 5'd8, 128'hffff_ff99);
        rows[13] = make_row(0, 0, SZ_BYTE_U, 32'h8000_0013, '0, 5'd10, 128'h0000_0099);
        rows[14] = make_row(0, 0, SZ_HALF,   32'h8000_0012, '0, 5'd11, 128'hffff_9977);
        rows[15] = make_row(0, 0, SZ_HALF_U, 32'h8000_0012, '0, 5'd12, 128'h0000_9977);
        rows[16] = make_row(0, 0, SZ_BYTE,   32'h8000_0011, '0, 5'd13, 128'h0000_0055);
        rows[17] = make_row(0, 0, SZ_BYTE,   32'h8000_0010, '0, 5'd14, 128'hffff_ffd4);
        rows[18] = make_row(0, 0, SZ_HALF,   32'h8000_0010, '0, 5'd15, 128'h0000_55d4);
    endtask

    task automatic run_row(input int i);
        lsu_req_t r;
        logic     is_global;
        logic     global_ld;
        int       waited;
        r.is_store  = rows[i].is_store;
        r.is_vector = rows[i].is_vector;
        r.size      = rows[i].size;
        r.addr      = rows[i].addr;
        r.wdata     = rows[i].wdata;
        r.rd        = rows[i].rd;
        is_global   = rows[i].addr[`LSU_GLOBAL_BIT];
        global_ld   = is_global && !rows[i].is_store;
        @(negedge clk);
        while (stall) begin
            @(negedge clk);
        end
        @(posedge clk);
        valid_in <= 1'b1;
        req      <= r;
        @(negedge clk);                                  // Issue cycle
        assert (global_req_valid === is_global)
            else report_mismatch("global_req_valid", global_req_valid, is_global);
        assert (local_req_valid === !is_global)
            else report_mismatch("local_req_valid", local_req_valid, !is_global);
        assert (stall === global_ld) else report_mismatch("stall", stall, global_ld);
        assert (!wb_valid) else stop_with_failure($sformatf("Row %0d wrote back early", i));
        @(posedge clk);
        valid_in <= 1'b0;
        if (!rows[i].is_store) begin
            waited = 0;
            do begin
                @(negedge clk);
                waited++;
                assert (!global_ld || stall)
                    else stop_with_failure($sformatf("Row %0d stall fell before writeback", i));
                assert (busy)
                    else stop_with_failure($sformatf("Row %0d busy low while a load is out", i));
            end while (!wb_valid);
            if (!global_ld) begin
                assert (waited == 1)
                    else stop_with_failure($sformatf("Row %0d local load took %0d cycles",
                                                     i, waited));
            end
            assert (wb.data === rows[i].exp)
                else report_mismatch("wb.data", wb.data, rows[i].exp);
            assert (wb.rd === rows[i].rd) else report_mismatch("wb.rd", wb.rd, rows[i].rd);
            assert (wb.is_vector === rows[i].is_vector)
                else report_mismatch("wb.is_vector", wb.is_vector, rows[i].is_vector);
        end
    endtask

    // ------------------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------------------
    initial begin
        valid_in = 1'b0;
        req      = '0;
        rst_n    = 1'b0;
        fill_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_idle("after reset");
        for (int i = 0; i < NUM_ROWS; i++) begin
            run_row(i);
        end
        repeat (2) @(negedge clk);   // Let the last row drain
        check_idle("after the last row");
        $display("** PASS **");
        $finish;
    end

endmodule

//--- tb/lsu_props.sv
`timescale 1ns/1ps

module global_port_props (
    input logic clk,
    input logic rst_n,
    input logic global_req_valid,
    input logic global_resp_valid,
    input logic load_issue,
    input logic load_wait,
    input logic wb_valid
);

    // ------------------------------------------------------------------------
    // Blocking load protocol
    // ------------------------------------------------------------------------

    // No new external strobe while a load is still out
    no_req_during_wait: assert property (
        @(posedge clk) disable iff (!rst_n) !(global_req_valid && load_wait)
    ) else $error("global request strobe while a load is outstanding");

    // Every response that lands during a wait is written back
    wb_matches_response: assert property (
        @(posedge clk) disable iff (!rst_n) wb_valid == (load_wait && global_resp_valid)
    ) else $error("global writeback does not line up with the response");

    // Responses only arrive for a load already out
    resp_only_while_waiting: assert property (
        @(posedge clk) disable iff (!rst_n) global_resp_valid |-> (load_wait && !load_issue)
    ) else $error("global response without an outstanding load");

endmodule

bind global_mem_port global_port_props u_props (
    .clk               (clk),
    .rst_n             (rst_n),
    .global_req_valid  (global_req_valid),
    .global_resp_valid (global_resp_valid),
    .load_issue        (load_issue),
    .load_wait         (load_wait),
    .wb_valid          (wb_valid)
);

//--- tb/lsu_mem_models.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

// Local BRAM with one 128-bit line per 16 bytes and read data one cycle later
module bram_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  lsu_pkg::local_req_t   req,
    output logic [`LSU_VEC_W-1:0] rdata
);

    logic [`LSU_VEC_W-1:0] mem [256];
    logic [7:0]            line;

    assign line = req.addr[11:4];

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rdata <= '0;
        end else if (req_valid && req.we) begin
            if (req.is_vector) begin
                mem[line] <= req.wdata;
            end else begin
                // Only the selected bank lane is written
                mem[line][req.bank_sel*`LSU_WORD_W +: `LSU_WORD_W] <=
                    req.wdata[req.bank_sel*`LSU_WORD_W +: `LSU_WORD_W];
            end
        end else if (req_valid) begin
            rdata <= mem[line];
        end
    end

endmodule

// External word memory that answers loads after 1 to 4 cycles
module global_mem_model (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  req_valid,
    input  lsu_pkg::global_req_t  req,
    output logic                  resp_valid,
    output lsu_pkg::global_resp_t resp
);

    logic [`LSU_WORD_W-1:0] mem [256];
    integer                 seed = 15054;
    int                     lat;
    logic                   pending;
    logic [2:0]             count;
    logic [7:0]             p_idx;
    logic [`LSU_REG_W-1:0]  p_rd;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            resp_valid <= 1'b0;
            resp       <= '0;
            pending    <= 1'b0;
            count      <= '0;
        end else begin
            resp_valid <= 1'b0;     // Single-cycle strobe
            if (req_valid && req.is_load) begin
                lat = ($random(seed) & 3) + 1;
                if (lat == 1) begin
                    resp_valid <= 1'b1;     // Answer in the next cycle
                    resp.rd    <= req.rd;
                    resp.data  <= mem[req.addr[9:2]];
                end else begin
                    pending <= 1'b1;
                    count   <= lat[2:0] - 3'd1;
                    p_idx   <= req.addr[9:2];
                    p_rd    <= req.rd;
                end
            end else if (req_valid) begin
                for (int b = 0; b < 4; b++) begin
                    if (req.wstrb[b]) begin
                        mem[req.addr[9:2]][8*b +: 8] <= req.wdata[8*b +: 8];
                    end
                end
            end else if (pending) begin
                count <= count - 3'd1;
                if (count == 3'd1) begin
                    pending    <= 1'b0;
                    resp_valid <= 1'b1;
                    resp.rd    <= p_rd;
                    resp.data  <= mem[p_idx];
                end
            end
        end
    end

endmodule

//--- hw/lsu_top.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module lsu_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    valid_in,
    input  lsu_pkg::lsu_req_t       req,
    output logic                    stall,
    output logic                    busy,
    output logic                    local_req_valid,
    output lsu_pkg::local_req_t     local_req,
    input  logic [`LSU_VEC_W-1:0]   local_rdata,
    output logic                    global_req_valid,
    output lsu_pkg::global_req_t    global_req,
    input  logic                    global_resp_valid,
    input  lsu_pkg::global_resp_t   global_resp,
    output logic                    wb_valid,
    output lsu_pkg::wb_t            wb
);

    import lsu_pkg::*;

    logic   is_global;
    logic   local_valid;
    logic   global_valid;

    logic   local_wb_valid;
    wb_t    local_wb;
    logic   global_wb_valid;
    wb_t    global_wb;
    logic   read_pending;
    logic   load_wait;
    logic   load_issue;

    // Address space decode
    assign is_global    = req.addr[`LSU_GLOBAL_BIT];
    assign local_valid  = valid_in && !is_global;
    assign global_valid = valid_in && is_global && !req.is_vector;   // Vector global dropped

    local_mem_port u_local (
        .clk             (clk),
        .rst_n           (rst_n),
        .local_valid     (local_valid),
        .req             (req),
        .local_req_valid (local_req_valid),
        .local_req       (local_req),
        .local_rdata     (local_rdata),
        .wb_valid        (local_wb_valid),
        .wb              (local_wb),
        .read_pending    (read_pending)
    );

    global_mem_port u_global (
        .clk               (clk),
        .rst_n             (rst_n),
        .global_valid      (global_valid),
        .req               (req),
        .global_req_valid  (global_req_valid),
        .global_req        (global_req),
        .global_resp_valid (global_resp_valid),
        .global_resp       (global_resp),
        .wb_valid          (global_wb_valid),
        .wb                (global_wb),
        .load_wait         (load_wait),
        .load_issue        (load_issue)
    );

    wb_combiner u_wb (
        .local_wb_valid  (local_wb_valid),
        .local_wb        (local_wb),
        .global_wb_valid (global_wb_valid),
        .global_wb       (global_wb),
        .read_pending    (read_pending),
        .load_wait       (load_wait),
        .load_issue      (load_issue),
        .wb_valid        (wb_valid),
        .wb              (wb),
        .stall           (stall),
        .busy            (busy)
    );

endmodule

//--- hw/wb_combiner.sv
`timescale 1ns/1ps

module wb_combiner (
    input  logic            local_wb_valid,
    input  lsu_pkg::wb_t    local_wb,
    input  logic            global_wb_valid,
    input  lsu_pkg::wb_t    global_wb,
    input  logic            read_pending,
    input  logic            load_wait,
    input  logic            load_issue,
    output logic            wb_valid,
    output lsu_pkg::wb_t    wb,
    output logic            stall,
    output logic            busy
);

    // ------------------------------------------------------------------------
    // Single register file write port
    // ------------------------------------------------------------------------

    // Global response takes the port if both ever line up
    always_comb begin
        if (global_wb_valid) begin
            wb = global_wb;
        end else begin
            wb = local_wb;
        end
    end

    assign wb_valid = local_wb_valid || global_wb_valid;

    // Pipeline holds from load issue until the response lands
    assign stall = load_issue || load_wait;

    // Any read still in flight
    assign busy  = read_pending || load_wait;

endmodule

//--- hw/global_mem_port.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module global_mem_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    global_valid,
    input  lsu_pkg::lsu_req_t       req,
    output logic                    global_req_valid,
    output lsu_pkg::global_req_t    global_req,
    input  logic                    global_resp_valid,
    input  lsu_pkg::global_resp_t   global_resp,
    output logic                    wb_valid,
    output lsu_pkg::wb_t            wb,
    output logic                    load_wait,
    output logic                    load_issue
);

    import lsu_pkg::*;

    logic [`LSU_WORD_W-1:0]  lane_data;
    logic [STRB_W-1:0]       lane_strb;
    logic                    resp_hit;

    // State of the single outstanding load
    logic [`LSU_REG_W-1:0]   r_rd;
    size_e                   r_size;
    logic [OFF_W-1:0]        r_off;

    assign load_issue = global_valid && !req.is_store;

    // ------------------------------------------------------------------------
    // External request
    // ------------------------------------------------------------------------
    always_comb begin
        store_lane(req.wdata[`LSU_WORD_W-1:0], req.size, req.addr[OFF_W-1:0],
                   lane_data, lane_strb);

        global_req_valid   = global_valid;
        global_req.is_load = !req.is_store;
        global_req.addr    = {req.addr[`LSU_ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        global_req.rd      = req.rd;
        if (req.is_store) begin
            global_req.wdata = lane_data;
            global_req.wstrb = lane_strb;
        end else begin
            global_req.wdata = '0;
            global_req.wstrb = '0;   // Loads fetch the whole word
        end
    end

    // ------------------------------------------------------------------------
    // Blocking load tracking
    // ------------------------------------------------------------------------
    assign resp_hit = load_wait && global_resp_valid && (global_resp.rd == r_rd);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_wait <= 1'b0;
        end else if (load_issue) begin
            load_wait <= 1'b1;
        end else if (resp_hit) begin
            load_wait <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load_issue) begin
            r_rd   <= req.rd;
            r_size <= req.size;
            r_off  <= req.addr[OFF_W-1:0];   // Kept for subword extract
        end
    end

    // Writeback on the response cycle
    always_comb begin
        wb_valid     = resp_hit;
        wb.is_vector = 1'b0;
        wb.rd        = r_rd;
        wb.data      = {{(`LSU_VEC_W-`LSU_WORD_W){1'b0}},
                        extract_subword(global_resp.data, r_size, r_off)};
    end

endmodule

//--- hw/local_mem_port.sv
`timescale 1ns/1ps
`include "lsu_cfg.svh"

module local_mem_port (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    local_valid,
    input  lsu_pkg::lsu_req_t       req,
    output logic                    local_req_valid,
    output lsu_pkg::local_req_t     local_req,
    input  logic [`LSU_VEC_W-1:0]   local_rdata,
    output logic                    wb_valid,
    output lsu_pkg::wb_t            wb,
    output logic                    read_pending
);

    import lsu_pkg::*;

    localparam int VEC_ALIGN = $clog2(`LSU_VEC_W / 8);   // 16-byte lines

    logic                    r_is_vector;
    logic [BANK_SEL_W-1:0]   r_bank;
    logic [`LSU_REG_W-1:0]   r_rd;
    logic                    read_issue;

    assign read_issue = local_valid && !req.is_store;

    // ------------------------------------------------------------------------
    // BRAM request, same cycle as the pipeline strobe
    // ------------------------------------------------------------------------
    always_comb begin
        local_req_valid     = local_valid;
        local_req.we        = req.is_store;
        local_req.is_vector = req.is_vector;
        if (req.is_vector) begin
            local_req.addr     = {req.addr[`LSU_ADDR_W-1:VEC_ALIGN], {VEC_ALIGN{1'b0}}};
            local_req.wdata    = req.wdata;
            local_req.bank_sel = '0;
        end else begin
            local_req.addr     = req.addr;
            // Scalar word is replicated, the bank select picks the lane
            local_req.wdata    = {`LSU_BANKS{req.wdata[`LSU_WORD_W-1:0]}};
            local_req.bank_sel = req.addr[BANK_SEL_W-1:0];
        end
    end

    // One-cycle read tracking
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_pending <= 1'b0;
        end else begin
            read_pending <= read_issue;
        end
    end

    always_ff @(posedge clk) begin
        if (read_issue) begin
            r_is_vector <= req.is_vector;
            r_bank      <= req.is_vector ? '0 : req.addr[BANK_SEL_W-1:0];
            r_rd        <= req.rd;
        end
    end

    // Writeback while the BRAM data is on the bus
    always_comb begin
        wb_valid     = read_pending;
        wb.is_vector = r_is_vector;
        wb.rd        = r_rd;
        if (r_is_vector) begin
            wb.data = local_rdata;
        end else begin
            wb.data = {{(`LSU_VEC_W-`LSU_WORD_W){1'b0}},
                       local_rdata[r_bank*`LSU_WORD_W +: `LSU_WORD_W]};   // Zero-extended lane
        end
    end

endmodule

//--- hw/lsu_pkg.sv
`include "lsu_cfg.svh"

package lsu_pkg;

    localparam int BANK_SEL_W = $clog2(`LSU_BANKS);
    localparam int STRB_W     = `LSU_WORD_W / 8;
    localparam int OFF_W      = $clog2(STRB_W);   // Byte offset inside a word

    // RISC-V style load/store size codes
    typedef enum logic [2:0] {
        SZ_BYTE   = 3'b000,
        SZ_HALF   = 3'b001,
        SZ_WORD   = 3'b010,
        SZ_BYTE_U = 3'b100,
        SZ_HALF_U = 3'b101
    } size_e;

    // ------------------------------------------------------------------------
    // Request, response and writeback records
    // ------------------------------------------------------------------------
    typedef struct packed {
        logic                   is_store;
        logic                   is_vector;
        size_e                  size;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_VEC_W-1:0]  wdata;
        logic [`LSU_REG_W-1:0]  rd;
    } lsu_req_t;

    typedef struct packed {
        logic                   we;
        logic                   is_vector;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_VEC_W-1:0]  wdata;
        logic [BANK_SEL_W-1:0]  bank_sel;
    } local_req_t;

    typedef struct packed {
        logic                   is_load;
        logic [`LSU_ADDR_W-1:0] addr;     // Always word aligned
        logic [`LSU_WORD_W-1:0] wdata;
        logic [STRB_W-1:0]      wstrb;
        logic [`LSU_REG_W-1:0]  rd;
    } global_req_t;

    typedef struct packed {
        logic [`LSU_REG_W-1:0]  rd;
        logic [`LSU_WORD_W-1:0] data;
    } global_resp_t;

    typedef struct packed {
        logic                   is_vector;
        logic [`LSU_REG_W-1:0]  rd;
        logic [`LSU_VEC_W-1:0]  data;
    } wb_t;

    // ------------------------------------------------------------------------
    // Subword helpers
    // ------------------------------------------------------------------------

    // Pick the addressed byte or half out of a loaded word and extend it
    function automatic logic [`LSU_WORD_W-1:0] extract_subword(
        input logic [`LSU_WORD_W-1:0] word,
        input size_e                  size,
        input logic [OFF_W-1:0]       byte_off
    );
        logic [7:0]  b;
        logic [15:0] h;
        b = word[{byte_off, 3'b000} +: 8];
        h = word[{byte_off[1], 4'b0000} +: 16];
        case (size)
            SZ_BYTE:   return {{(`LSU_WORD_W-8){b[7]}}, b};
            SZ_HALF:   return {{(`LSU_WORD_W-16){h[15]}}, h};
            SZ_BYTE_U: return {{(`LSU_WORD_W-8){1'b0}}, b};
            SZ_HALF_U: return {{(`LSU_WORD_W-16){1'b0}}, h};
            default:   return word;   // Word
        endcase
    endfunction

    // Move store data into its byte lanes and build the matching strobe
    function automatic void store_lane(
        input  logic [`LSU_WORD_W-1:0] data,
        input  size_e                  size,
        input  logic [OFF_W-1:0]       byte_off,
        output logic [`LSU_WORD_W-1:0] lane_data,
        output logic [STRB_W-1:0]      lane_strb
    );
        case (size)
            SZ_BYTE, SZ_BYTE_U: begin
                lane_data = {{(`LSU_WORD_W-8){1'b0}}, data[7:0]} << {byte_off, 3'b000};
                lane_strb = {{(STRB_W-1){1'b0}}, 1'b1} << byte_off;
            end
            SZ_HALF, SZ_HALF_U: begin
                lane_data = {{(`LSU_WORD_W-16){1'b0}}, data[15:0]} << {byte_off[1], 4'b0000};
                lane_strb = {{(STRB_W-2){1'b0}}, 2'b11} << {byte_off[1], 1'b0};
            end
            default: begin
                lane_data = data;
                lane_strb = '1;
            end
        endcase
    endfunction

endpackage

//--- hw/lsu_cfg.svh
`ifndef LSU_CFG_SVH
`define LSU_CFG_SVH

// ---------------------------------------------------------------------------
// Load/store unit sizing
// ---------------------------------------------------------------------------

`define LSU_ADDR_W      32   // Byte address width
`define LSU_WORD_W      32   // Scalar register width
`define LSU_VEC_W       128  // Vector register width
`define LSU_REG_W       5    // Register file index width

// Address map

// Upper address bit set means the access goes to external memory
`define LSU_GLOBAL_BIT  31

// Local BRAM is split into word-wide banks across the vector width
`define LSU_BANKS       4

`endif
